//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = tb_gate_preact
FILELIST  = tb.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q -F '** FAIL **' $(LOG); then \
		echo "Simulation failed"; \
		exit 1; \
	fi
	@if ! grep -q -F '** PASS **' $(LOG); then \
		echo "Simulation ended without a result"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- design/gate_bias.sv
`timescale 1ns/100ps

module gate_bias (
        input  logic              clk,
        input  logic              i_rst_n,

        input  logic              i_ld_valid,
        input  lstm_pkg::ld_sel_t i_ld_sel,
        input  lstm_pkg::data_t   i_ld_data,
        output logic              o_ld_ready,

        input  logic              i_cmd_valid,
        input  logic              i_cmd_update,
        input  lstm_pkg::data_t   i_cmd_delta,
        output logic              o_cmd_ready,

        output logic              o_start,
        output logic              o_update,
        output lstm_pkg::data_t   o_delta,

        input  logic              i_x_sum_valid,
        input  lstm_pkg::acc_t    i_x_sum,
        input  logic              i_h_sum_valid,
        input  lstm_pkg::acc_t    i_h_sum,
        output logic              o_take,

        output logic              o_res_valid,
        output lstm_pkg::data_t   o_res_data,
        input  logic              i_res_ready
);

        typedef enum logic [1:0] {ST_IDLE, ST_BUSY, ST_RES} state_t;

        state_t          state;
        logic            start_q;
        logic            upd_q;
        lstm_pkg::data_t delta_q;
        lstm_pkg::data_t bias_q;
        lstm_pkg::data_t res_q;

        lstm_pkg::acc_t  sum_all;
        lstm_pkg::data_t sat_sum;
        lstm_pkg::data_t new_bias;
        logic            cmd_fire;
        logic            in_range;

        assign cmd_fire = i_cmd_valid && (state == ST_IDLE);
        assign o_take   = (state == ST_BUSY) && i_x_sum_valid && i_h_sum_valid;

        //////////////////////////////
        // Bias combine and saturate
        //////////////////////////////

        assign sum_all  = i_x_sum + i_h_sum + lstm_pkg::acc_t'(bias_q);
        assign in_range = (&sum_all[lstm_pkg::ACC_W-1:lstm_pkg::WIDTH-1])
                          || !(|sum_all[lstm_pkg::ACC_W-1:lstm_pkg::WIDTH-1]);
        assign new_bias = bias_q - (delta_q >>> lstm_pkg::LR_SHIFT);

        always_comb begin
                if (in_range) begin
                        sat_sum = sum_all[lstm_pkg::WIDTH-1:0];
                end else if (sum_all[lstm_pkg::ACC_W-1]) begin
                        sat_sum = {1'b1, {(lstm_pkg::WIDTH-1){1'b0}}};
                end else begin
                        sat_sum = {1'b0, {(lstm_pkg::WIDTH-1){1'b1}}};
                end
        end

        //////////////////////////////
        // Command FSM
        //////////////////////////////

        always_ff @(posedge clk) begin
                if (!i_rst_n) begin
                        state   <= ST_IDLE;
                        start_q <= 1'b0;
                        upd_q   <= 1'b0;
                end else begin
                        start_q <= cmd_fire;
                        case (state)
                        ST_IDLE: if (cmd_fire) begin
                                upd_q <= i_cmd_update;
                                state <= ST_BUSY;
                        end
                        ST_BUSY: if (o_take) begin
                                state <= ST_RES;
                        end
                        ST_RES: if (i_res_ready) begin
                                state <= ST_IDLE;
                        end
                        default: state <= ST_IDLE;
                        endcase
                end
        end

        always_ff @(posedge clk) begin
                if (cmd_fire) begin
                        delta_q <= i_cmd_delta;
                end
                if (o_take) begin
                        res_q <= upd_q ? new_bias : sat_sum;
                end
        end

        // Loads only land while idle
        always_ff @(posedge clk) begin
                if (i_ld_valid && o_ld_ready && (i_ld_sel == lstm_pkg::LD_B)) begin
                        bias_q <= i_ld_data;
                end else if (o_take && upd_q) begin
                        bias_q <= new_bias;
                end
        end

        assign o_ld_ready  = (state == ST_IDLE);
        assign o_cmd_ready = (state == ST_IDLE);
        assign o_start     = start_q;
        assign o_update    = upd_q;
        assign o_delta     = delta_q;
        assign o_res_valid = (state == ST_RES);
        assign o_res_data  = res_q;

endmodule

//--- design/gate_mac.sv
`timescale 1ns/100ps

module gate_mac #(
        parameter int                N_TERMS  = lstm_pkg::N_IN,
        parameter lstm_pkg::ld_sel_t LANE_SEL = lstm_pkg::LD_W
) (
        input  logic                          clk,
        input  logic                          i_rst_n,

        input  logic                          i_ld_valid,
        input  lstm_pkg::ld_sel_t             i_ld_sel,
        input  logic [lstm_pkg::ADDR_W-1:0]   i_ld_addr,
        input  lstm_pkg::data_t               i_ld_data,

        input  logic                          i_start,
        input  logic                          i_update,
        input  lstm_pkg::data_t               i_delta,

        input  logic                          i_term_valid,
        output logic                          o_term_ready,
        input  lstm_pkg::data_t               i_term_data,

        output logic                          o_sum_valid,
        output lstm_pkg::acc_t                o_sum,
        input  logic                          i_take
);

        localparam int CNT_W = (N_TERMS > 1) ? $clog2(N_TERMS) : 1;

        lstm_pkg::data_t                     weight_mem [N_TERMS];
        logic [CNT_W-1:0]                    cnt;
        logic                                active;
        logic                                sum_valid;
        lstm_pkg::acc_t                      acc;

        lstm_pkg::data_t                     w_rd;
        lstm_pkg::data_t                     mul_a;
        lstm_pkg::data_t                     mul_b;
        logic signed [2*lstm_pkg::WIDTH-1:0] prod;
        logic signed [2*lstm_pkg::WIDTH-1:0] prod_sh;

        logic                                term_fire;
        logic                                last_term;
        logic                                ld_hit;

        //////////////////////////////
        // Datapath
        //////////////////////////////

        assign term_fire = i_term_valid && active;
        assign last_term = (int'(cnt) == N_TERMS - 1);

        // Only this lane's selector, and only addresses it holds
        assign ld_hit = i_ld_valid && (i_ld_sel == LANE_SEL) && (int'(i_ld_addr) < N_TERMS);

        assign w_rd = weight_mem[cnt];

        // One multiplier for w*x forward and delta*(x/8) on update
        assign mul_a   = i_update ? i_delta : w_rd;
        assign mul_b   = i_update ? (i_term_data >>> lstm_pkg::LR_SHIFT) : i_term_data;
        assign prod    = mul_a * mul_b;
        assign prod_sh = prod >>> lstm_pkg::FRAC;

        //////////////////////////////
        // Weight memory
        //////////////////////////////

        always_ff @(posedge clk) begin
                if (term_fire && i_update) begin
                        weight_mem[cnt] <= w_rd - lstm_pkg::data_t'(prod_sh);
                end else if (ld_hit) begin
                        weight_mem[i_ld_addr[CNT_W-1:0]] <= i_ld_data;
                end
        end

        //////////////////////////////
        // Term sequencing
        //////////////////////////////

        always_ff @(posedge clk) begin
                if (!i_rst_n) begin
                        active    <= 1'b0;
                        sum_valid <= 1'b0;
                        cnt       <= '0;
                end else begin
                        if (i_start) begin
                                active <= 1'b1;
                                cnt    <= '0;
                        end else if (term_fire) begin
                                if (last_term) begin
                                        active    <= 1'b0;
                                        sum_valid <= 1'b1;
                                end else begin
                                        cnt <= cnt + 1'b1;
                                end
                        end

                        // Sum is held until the bias stage takes it
                        if (i_take) begin
                                sum_valid <= 1'b0;
                        end
                end
        end

        // Stays zero through an update pass
        always_ff @(posedge clk) begin
                if (i_start) begin
                        acc <= '0;
                end else if (term_fire && !i_update) begin
                        acc <= acc + lstm_pkg::acc_t'(prod_sh);
                end
        end

        assign o_term_ready = active;
        assign o_sum_valid  = sum_valid;
        assign o_sum        = acc;

endmodule

//--- design/gate_preact.sv
`timescale 1ns/100ps

module gate_preact (
        input  logic                        clk,
        input  logic                        i_rst_n,

        input  logic                        i_ld_valid,
        input  lstm_pkg::ld_sel_t           i_ld_sel,
        input  logic [lstm_pkg::ADDR_W-1:0] i_ld_addr,
        input  lstm_pkg::data_t             i_ld_data,
        output logic                        o_ld_ready,

        input  logic                        i_cmd_valid,
        input  logic                        i_cmd_update,
        input  lstm_pkg::data_t             i_cmd_delta,
        output logic                        o_cmd_ready,

        input  logic                        i_x_valid,
        output logic                        o_x_ready,
        input  lstm_pkg::data_t             i_x_data,

        input  logic                        i_h_valid,
        output logic                        o_h_ready,
        input  lstm_pkg::data_t             i_h_data,

        output logic                        o_res_valid,
        output lstm_pkg::data_t             o_res_data,
        input  logic                        i_res_ready
);

        logic            ld_wr;
        logic            start;
        logic            update;
        lstm_pkg::data_t delta;
        logic            take;
        logic            x_sum_valid;
        lstm_pkg::acc_t  x_sum;
        logic            h_sum_valid;
        lstm_pkg::acc_t  h_sum;

        // Weight writes follow the same handshake as the bias
        assign ld_wr = i_ld_valid && o_ld_ready;

        //////////////////////////////
        // Input path for W times x
        //////////////////////////////

        gate_mac #(
                .N_TERMS  (lstm_pkg::N_IN),
                .LANE_SEL (lstm_pkg::LD_W)
        ) u_x_lane (
                .clk          (clk),
                .i_rst_n      (i_rst_n),
                .i_ld_valid   (ld_wr),
                .i_ld_sel     (i_ld_sel),
                .i_ld_addr    (i_ld_addr),
                .i_ld_data    (i_ld_data),
                .i_start      (start),
                .i_update     (update),
                .i_delta      (delta),
                .i_term_valid (i_x_valid),
                .o_term_ready (o_x_ready),
                .i_term_data  (i_x_data),
                .o_sum_valid  (x_sum_valid),
                .o_sum        (x_sum),
                .i_take       (take)
        );

        //////////////////////////////
        // Recurrent path for U times h
        //////////////////////////////

        gate_mac #(
                .N_TERMS  (lstm_pkg::N_HID),
                .LANE_SEL (lstm_pkg::LD_U)
        ) u_h_lane (
                .clk          (clk),
                .i_rst_n      (i_rst_n),
                .i_ld_valid   (ld_wr),
                .i_ld_sel     (i_ld_sel),
                .i_ld_addr    (i_ld_addr),
                .i_ld_data    (i_ld_data),
                .i_start      (start),
                .i_update     (update),
                .i_delta      (delta),
                .i_term_valid (i_h_valid),
                .o_term_ready (o_h_ready),
                .i_term_data  (i_h_data),
                .o_sum_valid  (h_sum_valid),
                .o_sum        (h_sum),
                .i_take       (take)
        );

        gate_bias u_bias (
                .clk           (clk),
                .i_rst_n       (i_rst_n),
                .i_ld_valid    (i_ld_valid),
                .i_ld_sel      (i_ld_sel),
                .i_ld_data     (i_ld_data),
                .o_ld_ready    (o_ld_ready),
                .i_cmd_valid   (i_cmd_valid),
                .i_cmd_update  (i_cmd_update),
                .i_cmd_delta   (i_cmd_delta),
                .o_cmd_ready   (o_cmd_ready),
                .o_start       (start),
                .o_update      (update),
                .o_delta       (delta),
                .i_x_sum_valid (x_sum_valid),
                .i_x_sum       (x_sum),
                .i_h_sum_valid (h_sum_valid),
                .i_h_sum       (h_sum),
                .o_take        (take),
                .o_res_valid   (o_res_valid),
                .o_res_data    (o_res_data),
                .i_res_ready   (i_res_ready)
        );

endmodule

//--- design/lstm_pkg.sv
package lstm_pkg;

        //////////////////////////////
        // Fixed-point format
        //////////////////////////////

        // Signed word with 20 fraction bits
        localparam int WIDTH = 24;
        localparam int FRAC  = 20;

        // Guard bits so that a full lane sum cannot wrap
        localparam int ACC_W = WIDTH + 8;

        //////////////////////////////
        // Vector sizes
        //////////////////////////////

        localparam int N_IN   = 8;
        localparam int N_HID  = 4;

        // Covers the longer of the two vectors
        localparam int ADDR_W = 3;

        // Learning rate of 1/8
        localparam int LR_SHIFT = 3;

        //////////////////////////////
        // Types and load selectors
        //////////////////////////////

        typedef logic signed [WIDTH-1:0] data_t;
        typedef logic signed [ACC_W-1:0] acc_t;
        typedef logic [1:0]              ld_sel_t;

        // Which memory a load targets
        localparam ld_sel_t LD_W = 2'd0;
        localparam ld_sel_t LD_U = 2'd1;
        localparam ld_sel_t LD_B = 2'd2;

endpackage

//--- tb.f
+incdir+tb
design/lstm_pkg.sv
design/gate_mac.sv
design/gate_bias.sv
design/gate_preact.sv
tb/tb_gate_preact.sv

//--- tb/gate_ref.svh
`ifndef GATE_REF_SVH
`define GATE_REF_SVH

// Expected values on 64-bit integers from the shadow weights and terms

function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] v;
        v = s;
        v = v ^ (v << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
endfunction

// Two's complement wrap to a data word
function automatic longint wrap_word(input longint v);
        lstm_pkg::data_t t;
        t = lstm_pkg::data_t'(v);
        return longint'(t);
endfunction

function automatic longint saturate_word(input longint v);
        longint hi;
        longint lo;
        hi = (longint'(1) <<< (lstm_pkg::WIDTH - 1)) - 1;
        lo = -(longint'(1) <<< (lstm_pkg::WIDTH - 1));
        if (v > hi) begin
                return hi;
        end
        if (v < lo) begin
                return lo;
        end
        return v;
endfunction

// Fraction bits dropped toward minus infinity
function automatic longint fix_mul(input longint a, input longint b);
        return (a * b) >>> lstm_pkg::FRAC;
endfunction

function automatic longint forward_ref();
        longint total;
        total = b_sh;
        for (int k = 0; k < lstm_pkg::N_IN; k++) begin
                total = total + fix_mul(w_sh[k], longint'(x_vec[k]));
        end
        for (int k = 0; k < lstm_pkg::N_HID; k++) begin
                total = total + fix_mul(u_sh[k], longint'(h_vec[k]));
        end
        return saturate_word(total);
endfunction

// Weight correction with a learning rate of 1/8 that returns the new bias
function automatic longint update_ref(input longint delta);
        for (int k = 0; k < lstm_pkg::N_IN; k++) begin
                w_sh[k] = wrap_word(w_sh[k]
                          - fix_mul(delta, longint'(x_vec[k]) >>> lstm_pkg::LR_SHIFT));
        end
        for (int k = 0; k < lstm_pkg::N_HID; k++) begin
                u_sh[k] = wrap_word(u_sh[k]
                          - fix_mul(delta, longint'(h_vec[k]) >>> lstm_pkg::LR_SHIFT));
        end
        b_sh = wrap_word(b_sh - (delta >>> lstm_pkg::LR_SHIFT));
        return b_sh;
endfunction

`endif

//--- tb/tb_gate_preact.sv
`timescale 1ns/100ps

module tb_gate_preact;

        // Longest pass is about 40 cycles and the whole run stays under 1000
        localparam int MAX_CYCLES = 4000;
        localparam int AW         = lstm_pkg::ADDR_W;

        logic                        clk = 1'b0;
        logic                        i_rst_n;
        logic                        i_ld_valid;
        lstm_pkg::ld_sel_t           i_ld_sel;
        logic [AW-1:0]               i_ld_addr;
        lstm_pkg::data_t             i_ld_data;
        logic                        o_ld_ready;
        logic                        i_cmd_valid;
        logic                        i_cmd_update;
        lstm_pkg::data_t             i_cmd_delta;
        logic                        o_cmd_ready;
        logic                        i_x_valid;
        logic                        o_x_ready;
        lstm_pkg::data_t             i_x_data;
        logic                        i_h_valid;
        logic                        o_h_ready;
        lstm_pkg::data_t             i_h_data;
        logic                        o_res_valid;
        lstm_pkg::data_t             o_res_data;
        logic                        i_res_ready;

        // Shadow weights and the terms of the current pass
        lstm_pkg::data_t             x_vec [lstm_pkg::N_IN];
        lstm_pkg::data_t             h_vec [lstm_pkg::N_HID];
        longint                      w_sh [lstm_pkg::N_IN];
        longint                      u_sh [lstm_pkg::N_HID];
        longint                      b_sh;

        longint                      exp_q [$];
        longint                      exp_now;
        logic [31:0]                 rng;
        int                          cycles = 0;
        int                          errors = 0;
        int                          checks = 0;
        int                          n_cmd = 0;
        int                          n_res = 0;
        int                          test_no = 0;
        int                          errs_start = 0;

        `include "gate_ref.svh"

        gate_preact i_gate_preact (
                .clk          (clk),
                .i_rst_n      (i_rst_n),
                .i_ld_valid   (i_ld_valid),
                .i_ld_sel     (i_ld_sel),
                .i_ld_addr    (i_ld_addr),
                .i_ld_data    (i_ld_data),
                .o_ld_ready   (o_ld_ready),
                .i_cmd_valid  (i_cmd_valid),
                .i_cmd_update (i_cmd_update),
                .i_cmd_delta  (i_cmd_delta),
                .o_cmd_ready  (o_cmd_ready),
                .i_x_valid    (i_x_valid),
                .o_x_ready    (o_x_ready),
                .i_x_data     (i_x_data),
                .i_h_valid    (i_h_valid),
                .o_h_ready    (o_h_ready),
                .i_h_data     (i_h_data),
                .o_res_valid  (o_res_valid),
                .o_res_data   (o_res_data),
                .i_res_ready  (i_res_ready)
        );

        always #20 clk = ~clk;

        always @(posedge clk) begin
                cycles <= cycles + 1;
                if (cycles >= MAX_CYCLES) begin
                        $display("Timeout, the run did not end within %0d cycles", MAX_CYCLES);
                        $display("** FAIL **");
                        $finish;
                end
        end

        //////////////////////////////
        // Result checker
        //////////////////////////////

        always @(posedge clk) begin
                if (o_res_valid && i_res_ready) begin
                        if (exp_q.size() == 0) begin
                                $display("A result came out with no command pending at %0t", $time);
                                errors++;
                        end else begin
                                exp_now = exp_q.pop_front();
                                checks++;
                                if (longint'(o_res_data) !== exp_now) begin
                                        $display("FAILED at %0t: result %0d, expected %0d",
                                                 $time, o_res_data, exp_now);
                                        errors++;
                                end
                        end
                        n_res++;
                end
        end

        //////////////////////////////
        // Stimulus helpers
        //////////////////////////////

        function logic [31:0] next_rand();
                rng = xorshift32(rng);
                return rng;
        endfunction

        // Signed word scaled down by a shift
        function automatic longint rand_data(input int shift);
                lstm_pkg::data_t d;
                d = lstm_pkg::data_t'(next_rand());
                return longint'(d) >>> shift;
        endfunction

        task automatic check_bit(input logic got, input logic want, input string what);
                checks++;
                if (got !== want) begin
                        $display("FAILED at %0t: %s is %b, expected %b", $time, what, got, want);
                        errors++;
                end
        endtask

        task automatic load_word(input lstm_pkg::ld_sel_t sel, input int addr, input longint value);
                @(posedge clk);
                i_ld_valid <= 1'b1;
                i_ld_sel   <= sel;
                i_ld_addr  <= AW'(addr);
                i_ld_data  <= lstm_pkg::data_t'(value);
                do @(posedge clk); while (!(i_ld_valid && o_ld_ready));
                i_ld_valid <= 1'b0;
                case (sel)
                lstm_pkg::LD_W: w_sh[addr] = value;
                lstm_pkg::LD_U: u_sh[addr] = value;
                default:        b_sh = value;
                endcase
        endtask

        task automatic load_random(input int shift);
                for (int k = 0; k < lstm_pkg::N_IN; k++) begin
                        load_word(lstm_pkg::LD_W, k, rand_data(shift));
                end
                for (int k = 0; k < lstm_pkg::N_HID; k++) begin
                        load_word(lstm_pkg::LD_U, k, rand_data(shift));
                end
                load_word(lstm_pkg::LD_B, 0, rand_data(shift));
        endtask

        task automatic randomize_terms(input int shift);
                for (int k = 0; k < lstm_pkg::N_IN; k++) begin
                        x_vec[k] = lstm_pkg::data_t'(rand_data(shift));
                end
                for (int k = 0; k < lstm_pkg::N_HID; k++) begin
                        h_vec[k] = lstm_pkg::data_t'(rand_data(shift));
                end
        endtask

        // Valid only drops after a handshake
        task automatic feed_x(input logic [31:0] seed, input bit gaps);
                int          idx;
                logic [31:0] s;
                logic        took;
                idx = 0;
                s   = seed;
                while (idx < lstm_pkg::N_IN) begin
                        @(posedge clk);
                        took = i_x_valid && o_x_ready;
                        s    = xorshift32(s);
                        if (took) begin
                                idx++;
                        end
                        if (idx == lstm_pkg::N_IN) begin
                                i_x_valid <= 1'b0;
                        end else begin
                                i_x_data <= x_vec[idx];
                                if (took || !i_x_valid) begin
                                        i_x_valid <= !gaps || (s[1:0] != 2'd0);
                                end
                        end
                end
        endtask

        task automatic feed_h(input logic [31:0] seed, input bit gaps);
                int          idx;
                logic [31:0] s;
                logic        took;
                idx = 0;
                s   = seed;
                while (idx < lstm_pkg::N_HID) begin
                        @(posedge clk);
                        took = i_h_valid && o_h_ready;
                        s    = xorshift32(s);
                        if (took) begin
                                idx++;
                        end
                        if (idx == lstm_pkg::N_HID) begin
                                i_h_valid <= 1'b0;
                        end else begin
                                i_h_data <= h_vec[idx];
                                if (took || !i_h_valid) begin
                                        i_h_valid <= !gaps || (s[1:0] != 2'd0);
                                end
                        end
                end
        endtask

        task automatic start_cmd(input bit upd, input longint delta, input bit gaps);
                logic [31:0] sx;
                logic [31:0] sh;
                if (upd) begin
                        exp_q.push_back(update_ref(delta));
                end else begin
                        exp_q.push_back(forward_ref());
                end
                n_cmd++;
                sx = next_rand();
                sh = next_rand();
                @(posedge clk);
                i_cmd_valid  <= 1'b1;
                i_cmd_update <= upd;
                i_cmd_delta  <= lstm_pkg::data_t'(delta);
                do @(posedge clk); while (!(i_cmd_valid && o_cmd_ready));
                i_cmd_valid <= 1'b0;
                fork
                        feed_x(sx, gaps);
                        feed_h(sh, gaps);
                join
        endtask

        task automatic wait_result();
                while (n_res < n_cmd) begin
                        @(posedge clk);
                end
        endtask

        task automatic begin_test();
                test_no++;
                errs_start = errors;
        endtask

        task automatic end_test(input string name);
                $display("Test %0d, %s: %0d errors", test_no, name, errors - errs_start);
        endtask

        //////////////////////////////
        // Test sequence
        //////////////////////////////

        initial begin
                lstm_pkg::data_t held;
                i_rst_n      <= 1'b0;
                i_ld_valid   <= 1'b0;
                i_ld_sel     <= lstm_pkg::LD_W;
                i_ld_addr    <= '0;
                i_ld_data    <= '0;
                i_cmd_valid  <= 1'b0;
                i_cmd_update <= 1'b0;
                i_cmd_delta  <= '0;
                i_x_valid    <= 1'b0;
                i_x_data     <= '0;
                i_h_valid    <= 1'b0;
                i_h_data     <= '0;
                i_res_ready  <= 1'b1;
                rng = 32'd56;
                repeat (4) @(posedge clk);
                i_rst_n <= 1'b1;

                begin_test();
                @(posedge clk);
                check_bit(o_res_valid, 1'b0, "o_res_valid");
                check_bit(o_x_ready, 1'b0, "o_x_ready");
                check_bit(o_h_ready, 1'b0, "o_h_ready");
                check_bit(o_cmd_ready, 1'b1, "o_cmd_ready");
                check_bit(o_ld_ready, 1'b1, "o_ld_ready");
                end_test("reset state");

                // Small fixed values without saturation
                begin_test();
                for (int k = 0; k < lstm_pkg::N_IN; k++) begin
                        load_word(lstm_pkg::LD_W, k, longint'(k + 1) <<< 17);
                        x_vec[k] = lstm_pkg::data_t'(longint'(k - 3) <<< 19);
                end
                for (int k = 0; k < lstm_pkg::N_HID; k++) begin
                        load_word(lstm_pkg::LD_U, k, -(longint'(k + 1) <<< 18));
                        h_vec[k] = lstm_pkg::data_t'(longint'(k + 1) <<< 20);
                end
                load_word(lstm_pkg::LD_B, 0, longint'(3) <<< 18);
                start_cmd(1'b0, 0, 1'b0);
                wait_result();
                end_test("known forward");

                begin_test();
                load_random(3);
                repeat (10) begin
                        randomize_terms(2);
                        start_cmd(1'b0, 0, 1'b1);
                        wait_result();
                end
                end_test("random forward");

                begin_test();
                repeat (3) begin
                        randomize_terms(2);
                        start_cmd(1'b1, rand_data(2), 1'b1);
                        wait_result();
                        randomize_terms(2);
                        start_cmd(1'b0, 0, 1'b1);
                        wait_result();
                end
                end_test("update then forward");

                begin_test();
                randomize_terms(2);
                @(posedge clk);
                i_res_ready <= 1'b0;
                start_cmd(1'b0, 0, 1'b1);
                while (!o_res_valid) begin
                        @(posedge clk);
                end
                held = o_res_data;
                repeat (6) begin
                        @(posedge clk);
                        check_bit(o_res_valid, 1'b1, "o_res_valid while stalled");
                        check_bit(o_cmd_ready, 1'b0, "o_cmd_ready while stalled");
                        check_bit(o_ld_ready, 1'b0, "o_ld_ready while stalled");
                        checks++;
                        if (o_res_data !== held) begin
                                $display("FAILED at %0t: stalled result moved from %0d to %0d",
                                         $time, held, o_res_data);
                                errors++;
                        end
                end
                i_res_ready <= 1'b1;
                wait_result();
                end_test("result stall");

                // Full scale weights and terms drive both limits
                begin_test();
                for (int k = 0; k < lstm_pkg::N_IN; k++) begin
                        load_word(lstm_pkg::LD_W, k, (longint'(1) <<< 23) - 1);
                        x_vec[k] = lstm_pkg::data_t'((longint'(1) <<< 23) - 1);
                end
                for (int k = 0; k < lstm_pkg::N_HID; k++) begin
                        load_word(lstm_pkg::LD_U, k, (longint'(1) <<< 23) - 1);
                        h_vec[k] = lstm_pkg::data_t'((longint'(1) <<< 23) - 1);
                end
                load_word(lstm_pkg::LD_B, 0, 0);
                start_cmd(1'b0, 0, 1'b1);
                wait_result();
                for (int k = 0; k < lstm_pkg::N_IN; k++) begin
                        x_vec[k] = lstm_pkg::data_t'(-(longint'(1) <<< 23));
                end
                for (int k = 0; k < lstm_pkg::N_HID; k++) begin
                        h_vec[k] = lstm_pkg::data_t'(-(longint'(1) <<< 23));
                end
                start_cmd(1'b0, 0, 1'b1);
                wait_result();
                end_test("saturation");

                $display("Done: %0d tests, %0d checks, %0d errors", test_no, checks, errors);
                if (errors == 0) begin
                        $display("** PASS **");
                end else begin
                        $display("** FAIL **");
                end
                $finish;
        end

endmodule
